// File: controlRequestFsm.sv
`timescale 1ns/1ps
`include "usbEp0_params.svh"

module controlRequestFsm (
    input  logic                    clk48_i,
    input  logic                    reset_i,
    input  logic                    startPacket_i,
    input  logic [1:0]              token_i,
    input  logic                    fillDone_i,
    input  logic                    fillSuccess_i,
    input  usbEp0Pkg::setupPacket_t setupPacket_i,
    input  usbEp0Pkg::deviceState_e deviceState_i,
    input  logic                    popDone_i,
    input  logic                    popSuccess_i,
    output usbEp0Pkg::ep0State_e    ep0State_o,
    output logic                    setAddress_o,
    output logic                    setConfig_o,
    output logic                    loadTransfer_o,
    output usbEp0Pkg::descType_e    descSel_o,
    output logic                    respHandshake_o,
    output logic [1:0]              respPid_o
);

    usbEp0Pkg::ep0State_e nextState;
    logic requestError;
    logic nextRequestError;
    logic dataToggle;
    logic [7:0] descType;
    logic hasAddress;
    logic setAddressOk;
    logic getDescOk;
    logic getConfOk;
    logic setConfOk;

    // ==================================================
    // Request checks
    // ==================================================
    assign descType = setupPacket_i.wValue[15:8];
    assign hasAddress = deviceState_i == usbEp0Pkg::ADDRESSED ||
        deviceState_i == usbEp0Pkg::CONFIGURED;

    // No address change once configured
    assign setAddressOk = setupPacket_i.bmRequestType == 8'h00 &&
        setupPacket_i.wValue < 16'd128 && deviceState_i != usbEp0Pkg::CONFIGURED;
    // Device descriptor, or a configuration index that exists
    assign getDescOk = setupPacket_i.bmRequestType == 8'h80 &&
        (descType == usbEp0Pkg::DEVICE || (descType == usbEp0Pkg::CONFIGURATION &&
        setupPacket_i.wValue[7:0] < 8'(`NUM_CONFIGURATIONS)));
    assign getConfOk = setupPacket_i.bmRequestType == 8'h80 &&
        setupPacket_i.wLength == 16'd1 && hasAddress;
    assign setConfOk = setupPacket_i.bmRequestType == 8'h00 &&
        setupPacket_i.wValue <= 16'(`NUM_CONFIGURATIONS) && hasAddress;

    assign descSel_o = (descType == usbEp0Pkg::CONFIGURATION) ?
        usbEp0Pkg::CONFIGURATION : usbEp0Pkg::DEVICE;

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        nextState = ep0State_o;
        nextRequestError = requestError;
        setAddress_o = 1'b0;
        setConfig_o = 1'b0;
        loadTransfer_o = 1'b0;

        if (startPacket_i) begin
            // Other tokens leave the state alone
            if (token_i == `TOKEN_SETUP) begin
                nextState = usbEp0Pkg::NEW_REQUEST;
                nextRequestError = 1'b0;
            end
        end else if (ep0State_o == usbEp0Pkg::NEW_REQUEST && fillDone_i) begin
            nextState = usbEp0Pkg::IDLE;
            if (fillSuccess_i) begin
                case (setupPacket_i.bRequest)
                    usbEp0Pkg::SET_ADDRESS: begin
                        setAddress_o = setAddressOk;
                        nextRequestError = !setAddressOk;
                    end
                    usbEp0Pkg::SET_CONFIGURATION: begin
                        setConfig_o = setConfOk;
                        nextRequestError = !setConfOk;
                    end
                    usbEp0Pkg::GET_DESCRIPTOR: begin
                        if (getDescOk) begin
                            nextState = usbEp0Pkg::SEND_DESC;
                            loadTransfer_o = 1'b1;
                        end else begin
                            nextRequestError = 1'b1;
                        end
                    end
                    usbEp0Pkg::GET_CONFIGURATION: begin
                        if (getConfOk) begin
                            nextState = usbEp0Pkg::SEND_VALUE;
                            loadTransfer_o = 1'b1;
                        end else begin
                            nextRequestError = 1'b1;
                        end
                    end
                    // Status, interface, feature and vendor requests stall
                    default: begin
                        nextRequestError = 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (reset_i) begin
            ep0State_o <= usbEp0Pkg::IDLE;
            requestError <= 1'b0;
            dataToggle <= 1'b0;
        end else begin
            ep0State_o <= nextState;
            requestError <= nextRequestError;
            // DATA0/DATA1 advances only on an acknowledged IN
            if (popDone_i && popSuccess_i) begin
                dataToggle <= !dataToggle;
            end
        end
    end

    // ==================================================
    // Response to the protocol engine
    // ==================================================
    // Handshake for host-to-device requests or any error
    assign respHandshake_o = !setupPacket_i.bmRequestType[7] || requestError;
    // Data PID upper bits are 00 for DATA0 and 10 for DATA1
    assign respPid_o = (token_i == `TOKEN_IN) ? {dataToggle, 1'b0} :
        (requestError ? `PID_STALL : `PID_ACK);

endmodule

// File: descriptorRom.sv
`timescale 1ns/1ps
`include "usbEp0_params.svh"

module descriptorRom (
    input  logic                  clk48_i,
    input  usbEp0Pkg::descType_e  loadSel_i,
    input  usbEp0Pkg::romIdx_t    readIdx_i,
    output usbEp0Pkg::romIdx_t    descStart_o,
    output usbEp0Pkg::byteCount_t descLength_o,
    output logic [7:0]            byte_o
);

    // ==================================================
    // Descriptor table
    // ==================================================
    localparam logic [7:0] ROM_TABLE [0:`EP0_ROM_BYTES-1] = '{
        // Device, USB 2.0, EP0 max packet 8, one configuration
        8'h12, 8'h01, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h08,
        8'h34, 8'h12, 8'h78, 8'h56, 8'h00, 8'h01, 8'h00, 8'h00,
        8'h00, 8'h01,
        // Configuration 1, total length 25, bus powered, 100 mA
        8'h09, 8'h02, 8'h19, 8'h00, 8'h01, 8'h01, 8'h00, 8'h80,
        8'h32,
        // Interface 0, one endpoint, vendor class
        8'h09, 8'h04, 8'h00, 8'h00, 8'h01, 8'hff, 8'h00, 8'h00,
        8'h00,
        // Endpoint 1 IN, bulk, 64 bytes
        8'h07, 8'h05, 8'h81, 8'h02, 8'h40, 8'h00, 8'h00
    };

    // ==================================================
    // Descriptor lookup
    // ==================================================
    // Selection follows the captured setup packet and settles
    // while the CRC bytes arrive, well before fill-done
    always_ff @(posedge clk48_i) begin
        if (loadSel_i == usbEp0Pkg::CONFIGURATION) begin
            descStart_o <= usbEp0Pkg::romIdx_t'(`CONF_DESC_START);
            descLength_o <= usbEp0Pkg::byteCount_t'(`CONF_TOTAL_LEN);
        end else begin
            descStart_o <= usbEp0Pkg::romIdx_t'(`DEV_DESC_START);
            descLength_o <= usbEp0Pkg::byteCount_t'(`DEV_DESC_LEN);
        end
    end

    // Byte at the in-flight index, zero past the table end
    assign byte_o = (readIdx_i < usbEp0Pkg::romIdx_t'(`EP0_ROM_BYTES)) ?
        ROM_TABLE[readIdx_i] : 8'h00;

endmodule

// File: deviceStateReg.sv
`timescale 1ns/1ps
`include "usbEp0_params.svh"

module deviceStateReg (
    input  logic                    clk48_i,
    input  logic                    reset_i,
    input  logic                    usbReset_i,
    input  logic                    setAddress_i,
    input  logic                    setConfig_i,
    input  logic [15:0]             value_i,
    output usbEp0Pkg::deviceState_e deviceState_o,
    output usbEp0Pkg::deviceAddr_t  deviceAddr_o,
    output usbEp0Pkg::deviceConf_t  deviceConf_o
);

    usbEp0Pkg::deviceAddr_t newAddr;
    usbEp0Pkg::deviceConf_t newConf;

    // wValue carries the new address or configuration
    assign newAddr = value_i[`USB_ADDR_WID-1:0];
    assign newConf = value_i[`USB_CONF_WID-1:0];

    always_ff @(posedge clk48_i) begin
        if (reset_i) begin
            // Power-up, wait for the first bus reset
            deviceState_o <= usbEp0Pkg::NOT_RESET;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (usbReset_i) begin
            deviceState_o <= usbEp0Pkg::DEFAULT;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (setConfig_i) begin
            deviceConf_o <= newConf;
            // Configuration 0 takes the device back to addressed
            if (newConf == '0) begin
                deviceState_o <= usbEp0Pkg::ADDRESSED;
            end else begin
                deviceState_o <= usbEp0Pkg::CONFIGURED;
            end
        end else if (setAddress_i) begin
            deviceAddr_o <= newAddr;
            // Address 0 means default address again
            if (newAddr == '0) begin
                deviceState_o <= usbEp0Pkg::DEFAULT;
            end else begin
                deviceState_o <= usbEp0Pkg::ADDRESSED;
            end
        end
    end

endmodule

// File: ep0_stimulus.txt
// setup 01: eight setup bytes, pid, addr, conf, pad | readIn 02 / failIn 03: count, pid, last, 8 bytes
// busReset 04: ackUsbReset | checkState 05: addr, conf, dataAvailable, inFull | 00 ends the list
05 00 00 00 01 00 00 00 00 00 00 00 00 00 00 00
04 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 00 05 2a 00 00 00 00 00 00 2a 00 00 00 00 00
01 80 06 00 01 00 00 40 00 00 2a 00 00 00 00 00
02 08 00 00 12 01 00 02 00 00 00 08 00 00 00 00
02 08 02 00 34 12 78 56 00 01 00 00 00 00 00 00
03 02 00 01 00 01 00 00 00 00 00 00 00 00 00 00
02 02 00 01 00 01 00 00 00 00 00 00 00 00 00 00
05 2a 00 00 01 00 00 00 00 00 00 00 00 00 00 00
01 00 09 01 00 00 00 00 00 00 2a 01 00 00 00 00
01 80 08 00 00 00 00 01 00 00 2a 01 00 00 00 00
02 01 02 01 01 00 00 00 00 00 00 00 00 00 00 00
05 2a 01 00 01 00 00 00 00 00 00 00 00 00 00 00
01 00 09 02 00 00 00 00 00 03 2a 01 00 00 00 00
01 80 00 00 00 00 00 02 00 03 2a 01 00 00 00 00
01 80 06 00 02 00 00 09 00 00 2a 01 00 00 00 00
02 08 00 00 09 02 19 00 01 01 00 80 00 00 00 00
02 01 02 01 32 00 00 00 00 00 00 00 00 00 00 00
04 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00
05 00 00 00 01 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

// File: files.f
+incdir+.
usbEp0Pkg.sv
setupPacketBuffer.sv
descriptorRom.sv
transferCounter.sv
deviceStateReg.sv
controlRequestFsm.sv
usbEndpoint0.sv
tb_usbEndpoint0.sv

// File: run.sh
#!/bin/sh
# Build and run the endpoint 0 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_usbEndpoint0 -f files.f -o simEp0
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simEp0)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: setupPacketBuffer.sv
`timescale 1ns/1ps
`include "usbEp0_params.svh"

module setupPacketBuffer (
    input  logic                    clk48_i,
    input  logic                    reset_i,
    input  logic                    startPacket_i,
    input  logic                    byteValid_i,
    input  logic [7:0]              byte_i,
    output logic                    full_o,
    output usbEp0Pkg::setupPacket_t setupPacket_o
);

    logic [3:0] byteCount;
    logic pidSkipped;
    logic [`SETUP_BYTES*8-1:0] shiftReg;
    logic byteAccept;

    // Extra bytes such as the CRC are dropped once full
    assign byteAccept = byteValid_i && !full_o;
    assign full_o = byteCount == 4'(`SETUP_BYTES);

    always_ff @(posedge clk48_i) begin
        if (reset_i || startPacket_i) begin
            byteCount <= 4'd0;
            pidSkipped <= 1'b0;
        end else if (byteAccept) begin
            // First byte of a data packet is its PID
            if (!pidSkipped) begin
                pidSkipped <= 1'b1;
            end else begin
                byteCount <= byteCount + 4'd1;
            end
        end
    end

    // New bytes enter at the top and move down
    always_ff @(posedge clk48_i) begin
        if (byteAccept && pidSkipped) begin
            shiftReg <= {byte_i, shiftReg[`SETUP_BYTES*8-1:8]};
        end
    end

    assign setupPacket_o = usbEp0Pkg::setupPacket_t'(shiftReg);

endmodule

// File: tb_usbEndpoint0.sv
`timescale 1ns/1ps
`include "usbEp0_params.svh"

module tb_usbEndpoint0;

    // Sixteen bytes per stimulus line
    localparam int REC_BYTES = 16;
    localparam int MAX_RECS = 64;

    logic clk48_i;
    logic reset_i;
    logic usbResetDetected_i;
    logic gotTransStartPacket_i;
    logic [1:0] transStartToken_i;
    logic epInDataValid_i;
    logic [7:0] epInData_i;
    logic epInFillDone_i;
    logic epInFillSuccess_i;
    logic epOutPop_i;
    logic epOutPopDone_i;
    logic epOutPopSuccess_i;
    logic ackUsbReset_o;
    usbEp0Pkg::deviceAddr_t deviceAddr_o;
    usbEp0Pkg::deviceConf_t deviceConf_o;
    logic epInFull_o;
    logic epOutDataAvailable_o;
    logic epOutLastByte_o;
    logic [7:0] epOutData_o;
    logic respHandshake_o;
    logic [1:0] respPid_o;

    logic [7:0] stimMem [0:REC_BYTES*MAX_RECS-1];
    int numRecs;
    bit recsLoaded = 1'b0;
    int errorCount;
    int failedTests;
    logic [31:0] rngState;

    usbEndpoint0 i_usbEndpoint0 (.*);

    // ==================================================
    // Clock and watchdog
    // ==================================================
    initial begin
        clk48_i = 1'b0;
        forever begin
            #50 clk48_i = !clk48_i;
        end
    end

    // Reset counts as one more test
    initial begin
        wait (recsLoaded);
        repeat ((numRecs + 1) * 400) @(posedge clk48_i);
        $display("timeout, the tests did not finish within %0d cycles", (numRecs + 1) * 400);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns, %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkAddr(input string name, input usbEp0Pkg::deviceAddr_t got,
                             input usbEp0Pkg::deviceAddr_t exp);
        if (got !== exp) begin
            $display("error at %0d ns, %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkConf(input string name, input usbEp0Pkg::deviceConf_t got,
                             input usbEp0Pkg::deviceConf_t exp);
        if (got !== exp) begin
            $display("error at %0d ns, %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkPid(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns, %s is %b, expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0d ns, %s is %b, expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // ==================================================
    // Bus drivers, all on the falling edge
    // ==================================================
    task automatic idleGap();
        rngState = xorshift32(rngState);
        repeat (rngState % 3) begin
            @(negedge clk48_i);
            epInDataValid_i = 1'b0;
        end
    endtask

    task automatic sendByte(input logic [7:0] value);
        @(negedge clk48_i);
        epInDataValid_i = 1'b1;
        epInData_i = value;
    endtask

    task automatic startToken(input logic [1:0] token);
        @(negedge clk48_i);
        gotTransStartPacket_i = 1'b1;
        transStartToken_i = token;
        @(negedge clk48_i);
        gotTransStartPacket_i = 1'b0;
    endtask

    // Setup stage, expected PID, address and configuration follow the packet
    task automatic runSetup(input int base);
        logic [1:0] expPid;
        logic expHandshake;
        expPid = stimMem[base + 9][1:0];
        expHandshake = !stimMem[base + 1][7] || expPid == `PID_STALL;
        rngState = xorshift32(rngState);
        startToken(`TOKEN_SETUP);
        checkFlag("epInFull_o", epInFull_o, 1'b0);
        // Data PID leads, DATA0 or DATA1 picked at random
        sendByte(rngState[0] ? 8'h4b : 8'hc3);
        for (int i = 1; i <= 8; i++) begin
            sendByte(stimMem[base + i]);
            idleGap();
        end
        // CRC bytes land on a full buffer
        sendByte(rngState[15:8]);
        sendByte(rngState[23:16]);
        @(negedge clk48_i);
        epInDataValid_i = 1'b0;
        checkFlag("epInFull_o", epInFull_o, 1'b1);
        epInFillDone_i = 1'b1;
        epInFillSuccess_i = 1'b1;
        @(negedge clk48_i);
        epInFillDone_i = 1'b0;
        epInFillSuccess_i = 1'b0;
        checkAddr("deviceAddr_o", deviceAddr_o, stimMem[base + 10][6:0]);
        checkConf("deviceConf_o", deviceConf_o, stimMem[base + 11]);
        checkPid("respPid_o", respPid_o, expPid);
        checkFlag("respHandshake_o", respHandshake_o, expHandshake);
    endtask

    // IN transaction, popped bytes then pop-done with the given outcome
    task automatic runRead(input int base, input bit success);
        int n;
        n = stimMem[base + 1];
        startToken(`TOKEN_IN);
        checkPid("respPid_o", respPid_o, stimMem[base + 2][1:0]);
        for (int k = 0; k < n; k++) begin
            // Output must hold across the gap
            idleGap();
            checkFlag("epOutDataAvailable_o", epOutDataAvailable_o, 1'b1);
            checkByte("epOutData_o", epOutData_o, stimMem[base + 4 + k]);
            checkFlag("epOutLastByte_o", epOutLastByte_o,
                      (k == n - 1) ? stimMem[base + 3][0] : 1'b0);
            epOutPop_i = 1'b1;
            @(negedge clk48_i);
            epOutPop_i = 1'b0;
        end
        epOutPopDone_i = 1'b1;
        epOutPopSuccess_i = success;
        @(negedge clk48_i);
        epOutPopDone_i = 1'b0;
        epOutPopSuccess_i = 1'b0;
    endtask

    task automatic runBusReset(input int base);
        @(negedge clk48_i);
        usbResetDetected_i = 1'b1;
        repeat (3) @(negedge clk48_i);
        usbResetDetected_i = 1'b0;
        @(negedge clk48_i);
        checkFlag("ackUsbReset_o", ackUsbReset_o, stimMem[base + 1][0]);
        checkAddr("deviceAddr_o", deviceAddr_o, '0);
        checkConf("deviceConf_o", deviceConf_o, '0);
    endtask

    task automatic runCheckState(input int base);
        @(negedge clk48_i);
        checkAddr("deviceAddr_o", deviceAddr_o, stimMem[base + 1][6:0]);
        checkConf("deviceConf_o", deviceConf_o, stimMem[base + 2]);
        checkFlag("epOutDataAvailable_o", epOutDataAvailable_o, stimMem[base + 3][0]);
        checkFlag("epInFull_o", epInFull_o, stimMem[base + 4][0]);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : mainSeq
        string opName;
        int base;
        int errorsBefore;
        reset_i = 1'b1;
        usbResetDetected_i = 1'b0;
        gotTransStartPacket_i = 1'b0;
        transStartToken_i = 2'b00;
        epInDataValid_i = 1'b0;
        epInData_i = 8'h00;
        epInFillDone_i = 1'b0;
        epInFillSuccess_i = 1'b0;
        epOutPop_i = 1'b0;
        epOutPopDone_i = 1'b0;
        epOutPopSuccess_i = 1'b0;
        rngState = 32'hd194;
        errorCount = 0;
        failedTests = 0;
        numRecs = 0;
        $readmemh("ep0_stimulus.txt", stimMem);
        // Operation code 00 ends the list
        while (numRecs < MAX_RECS && stimMem[numRecs * REC_BYTES] != 8'h00) begin
            numRecs++;
        end
        recsLoaded = 1'b1;
        repeat (10) @(negedge clk48_i);
        reset_i = 1'b0;
        if (numRecs == 0) begin
            $display("no test records were found in ep0_stimulus.txt");
            errorCount++;
        end
        for (int t = 0; t < numRecs; t++) begin
            base = t * REC_BYTES;
            errorsBefore = errorCount;
            case (stimMem[base])
                8'h01: begin
                    opName = "setup";
                    runSetup(base);
                end
                8'h02: begin
                    opName = "readIn";
                    runRead(base, 1'b1);
                end
                8'h03: begin
                    opName = "failIn";
                    runRead(base, 1'b0);
                end
                8'h04: begin
                    opName = "busReset";
                    runBusReset(base);
                end
                8'h05: begin
                    opName = "checkState";
                    runCheckState(base);
                end
                default: begin
                    opName = "unknown";
                    $display("record %0d has an unknown operation code %h", t, stimMem[base]);
                    errorCount++;
                end
            endcase
            if (errorCount == errorsBefore) begin
                $display("test %0d %s ok", t, opName);
            end else begin
                failedTests++;
                $display("test %0d %s failed", t, opName);
            end
        end
        $display("%0d tests, %0d ok, %0d failed, %0d errors",
                 numRecs, numRecs - failedTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: transferCounter.sv
`timescale 1ns/1ps

module transferCounter (
    input  logic                  clk48_i,
    input  logic                  reset_i,
    input  logic                  load_i,
    input  usbEp0Pkg::romIdx_t    loadStart_i,
    input  usbEp0Pkg::byteCount_t loadCount_i,
    input  logic                  pop_i,
    input  logic                  popDone_i,
    input  logic                  popSuccess_i,
    output usbEp0Pkg::romIdx_t    readIdx_o,
    output usbEp0Pkg::byteCount_t bytesLeft_o
);

    // Committed position, last acknowledged IN transaction
    usbEp0Pkg::romIdx_t commitIdx;
    usbEp0Pkg::byteCount_t commitLeft;
    // In-flight position, current IN transaction
    usbEp0Pkg::romIdx_t flightIdx;
    usbEp0Pkg::byteCount_t flightLeft;

    always_ff @(posedge clk48_i) begin
        if (reset_i) begin
            commitIdx <= '0;
            commitLeft <= '0;
            flightIdx <= '0;
            flightLeft <= '0;
        end else if (load_i) begin
            commitIdx <= loadStart_i;
            commitLeft <= loadCount_i;
            flightIdx <= loadStart_i;
            flightLeft <= loadCount_i;
        end else if (pop_i) begin
            flightIdx <= flightIdx + 1'b1;
            flightLeft <= flightLeft - 1'b1;
        end else if (popDone_i) begin
            if (popSuccess_i) begin
                // Host got the data
                commitIdx <= flightIdx;
                commitLeft <= flightLeft;
            end else begin
                // Host will ask again, replay the same bytes
                flightIdx <= commitIdx;
                flightLeft <= commitLeft;
            end
        end
    end

    assign readIdx_o = flightIdx;
    assign bytesLeft_o = flightLeft;

endmodule

// File: usbEndpoint0.sv
`timescale 1ns/1ps

module usbEndpoint0 (
    input  logic                   clk48_i,
    input  logic                   reset_i,

    input  logic                   usbResetDetected_i,
    output logic                   ackUsbReset_o,
    output usbEp0Pkg::deviceAddr_t deviceAddr_o,
    output usbEp0Pkg::deviceConf_t deviceConf_o,

    input  logic                   gotTransStartPacket_i,
    input  logic [1:0]             transStartToken_i,

    // Setup data from the host
    input  logic                   epInDataValid_i,
    input  logic [7:0]             epInData_i,
    input  logic                   epInFillDone_i,
    input  logic                   epInFillSuccess_i,
    output logic                   epInFull_o,

    // Answer bytes to the host
    input  logic                   epOutPop_i,
    input  logic                   epOutPopDone_i,
    input  logic                   epOutPopSuccess_i,
    output logic                   epOutDataAvailable_o,
    output logic                   epOutLastByte_o,
    output logic [7:0]             epOutData_o,

    output logic                   respHandshake_o,
    output logic [1:0]             respPid_o
);

    usbEp0Pkg::setupPacket_t setupPacket;
    usbEp0Pkg::ep0State_e ep0State;
    usbEp0Pkg::deviceState_e deviceState;
    usbEp0Pkg::descType_e descSel;
    usbEp0Pkg::romIdx_t descStart;
    usbEp0Pkg::romIdx_t readIdx;
    usbEp0Pkg::byteCount_t descLength;
    usbEp0Pkg::byteCount_t bytesLeft;
    usbEp0Pkg::byteCount_t transferCount;
    logic [7:0] romByte;
    logic bufFull;
    logic captureValid;
    logic setAddress;
    logic setConfig;
    logic loadTransfer;
    logic popAccept;
    logic epReset;

    // Bus reset also aborts the running transfer
    assign epReset = reset_i || usbResetDetected_i;

    // Setup bytes only while a request is expected
    assign captureValid = epInDataValid_i && ep0State == usbEp0Pkg::NEW_REQUEST;
    assign popAccept = epOutPop_i && epOutDataAvailable_o;

    // Host may ask for less than the descriptor holds
    assign transferCount = (setupPacket.bRequest == usbEp0Pkg::GET_CONFIGURATION) ?
        usbEp0Pkg::byteCount_t'(1) :
        ((setupPacket.wLength < descLength) ? setupPacket.wLength : descLength);

    setupPacketBuffer i_setupPacketBuffer (
        .clk48_i      (clk48_i),
        .reset_i      (reset_i),
        .startPacket_i(gotTransStartPacket_i),
        .byteValid_i  (captureValid),
        .byte_i       (epInData_i),
        .full_o       (bufFull),
        .setupPacket_o(setupPacket)
    );

    controlRequestFsm i_controlRequestFsm (
        .clk48_i        (clk48_i),
        .reset_i        (epReset),
        .startPacket_i  (gotTransStartPacket_i),
        .token_i        (transStartToken_i),
        .fillDone_i     (epInFillDone_i),
        .fillSuccess_i  (epInFillSuccess_i),
        .setupPacket_i  (setupPacket),
        .deviceState_i  (deviceState),
        .popDone_i      (epOutPopDone_i),
        .popSuccess_i   (epOutPopSuccess_i),
        .ep0State_o     (ep0State),
        .setAddress_o   (setAddress),
        .setConfig_o    (setConfig),
        .loadTransfer_o (loadTransfer),
        .descSel_o      (descSel),
        .respHandshake_o(respHandshake_o),
        .respPid_o      (respPid_o)
    );

    descriptorRom i_descriptorRom (
        .clk48_i     (clk48_i),
        .loadSel_i   (descSel),
        .readIdx_i   (readIdx),
        .descStart_o (descStart),
        .descLength_o(descLength),
        .byte_o      (romByte)
    );

    transferCounter i_transferCounter (
        .clk48_i     (clk48_i),
        .reset_i     (epReset),
        .load_i      (loadTransfer),
        .loadStart_i (descStart),
        .loadCount_i (transferCount),
        .pop_i       (popAccept),
        .popDone_i   (epOutPopDone_i),
        .popSuccess_i(epOutPopSuccess_i),
        .readIdx_o   (readIdx),
        .bytesLeft_o (bytesLeft)
    );

    deviceStateReg i_deviceStateReg (
        .clk48_i      (clk48_i),
        .reset_i      (reset_i),
        .usbReset_i   (usbResetDetected_i),
        .setAddress_i (setAddress),
        .setConfig_i  (setConfig),
        .value_i      (setupPacket.wValue),
        .deviceState_o(deviceState),
        .deviceAddr_o (deviceAddr_o),
        .deviceConf_o (deviceConf_o)
    );

    // ==================================================
    // Endpoint outputs
    // ==================================================
    assign ackUsbReset_o = deviceState == usbEp0Pkg::DEFAULT;
    assign epInFull_o = bufFull || ep0State != usbEp0Pkg::NEW_REQUEST;
    assign epOutDataAvailable_o = bytesLeft != '0 &&
        (ep0State == usbEp0Pkg::SEND_DESC || ep0State == usbEp0Pkg::SEND_VALUE);
    assign epOutLastByte_o = bytesLeft == usbEp0Pkg::byteCount_t'(1);
    // GET_CONFIGURATION answers with the current value
    assign epOutData_o = (ep0State == usbEp0Pkg::SEND_VALUE) ? deviceConf_o : romByte;

endmodule

// File: usbEp0Pkg.sv
`include "usbEp0_params.svh"

package usbEp0Pkg;

    typedef logic [`USB_ADDR_WID-1:0] deviceAddr_t;
    typedef logic [`USB_CONF_WID-1:0] deviceConf_t;
    typedef logic [`ROM_IDX_WID-1:0] romIdx_t;
    typedef logic [15:0] byteCount_t;

    // USB device states as seen by the host
    typedef enum logic [1:0] {
        NOT_RESET,
        DEFAULT,
        ADDRESSED,
        CONFIGURED
    } deviceState_e;

    // What endpoint 0 expects or offers next
    typedef enum logic [1:0] {
        NEW_REQUEST,
        SEND_DESC,
        SEND_VALUE,
        IDLE
    } ep0State_e;

    // Standard bRequest codes
    typedef enum logic [7:0] {
        GET_STATUS        = 8'd0,
        CLEAR_FEATURE     = 8'd1,
        SET_FEATURE       = 8'd3,
        SET_ADDRESS       = 8'd5,
        GET_DESCRIPTOR    = 8'd6,
        SET_DESCRIPTOR    = 8'd7,
        GET_CONFIGURATION = 8'd8,
        SET_CONFIGURATION = 8'd9,
        GET_INTERFACE     = 8'd10,
        SET_INTERFACE     = 8'd11,
        SYNCH_FRAME       = 8'd12
    } requestCode_e;

    // Descriptor type, high byte of wValue in GET_DESCRIPTOR
    typedef enum logic [7:0] {
        DEVICE        = 8'd1,
        CONFIGURATION = 8'd2
    } descType_e;

    // Little endian on the wire, byte 0 lands in the low bits
    typedef struct packed {
        logic [15:0] wLength;
        logic [15:0] wIndex;
        logic [15:0] wValue;
        logic [7:0] bRequest;
        logic [7:0] bmRequestType;
    } setupPacket_t;

endpackage

// File: usbEp0_params.svh
`ifndef USB_EP0_PARAMS_SVH
`define USB_EP0_PARAMS_SVH

// Device address and configuration value widths
`define USB_ADDR_WID 7
`define USB_CONF_WID 8

// Setup packet size without the data PID
`define SETUP_BYTES 8

// Descriptor ROM geometry
`define EP0_ROM_BYTES 43
`define ROM_IDX_WID 6

// Device descriptor placement
`define DEV_DESC_START 0
`define DEV_DESC_LEN 18

// Configuration, interface and endpoint descriptors, read as one block
`define CONF_DESC_START 18
`define CONF_TOTAL_LEN 25
`define NUM_CONFIGURATIONS 1

// Token and handshake codes, upper two PID bits
`define TOKEN_SETUP 2'b11
`define TOKEN_IN 2'b10
`define PID_ACK 2'b00
`define PID_STALL 2'b11

`endif
